// ==== life_stimulus.txt ====
# record columns: command, then arguments; row numbers and cycles decimal, row data hex
# load <row> <data> | clear | press <cycles> | hold <cycles> | view <row> <data> | gens <n> | grid
clear
load 5 0070
view 5 0070
view 4 0000
gens 0
press 4
gens 0
press 20
gens 1
view 4 0020
view 5 0020
view 6 0020
view 7 0000
grid
clear
load 13 4000
load 14 8000
load 15 e000
press 20
press 20
press 20
press 20
gens 5
view 14 8000
view 15 0001
view 0 c001
view 13 0000
hold 150
grid

// ==== src.f ====
life_grid_pkg.sv
life_ctrl_pkg.sv
press_timer.sv
button_debounce.sv
generation_sequencer.sv
cell_ram.sv
life_rule_pipe.sv
life_top.sv
tb_life_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the life testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -f src.f --top-module tb_life_top
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_life_top > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "tests failed" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

echo "simulation PASSED"
exit 0

// ==== tb_life_top.sv ====
// testbench for life_top, replays life_stimulus.txt against a software torus model
// compile with src.f, top module tb_life_top
`timescale 1ns/1ns
`default_nettype none

module tb_life_top;

	localparam int ROWS = life_grid_pkg::GRID_ROWS;
	localparam int COLS = life_grid_pkg::GRID_COLS;
	localparam int SWEEP = life_grid_pkg::GRID_ROWS + life_grid_pkg::PIPE_DELAY + 2;
	// sync flops, release wait, some margin
	localparam int SETTLE = 3 + life_ctrl_pkg::RELEASE_CYCLES + 8;

	typedef logic [63:0] word_t;

	logic clk;
	logic reset;
	logic button;
	logic load_strobe;
	life_grid_pkg::row_addr_t load_row;
	life_grid_pkg::row_t load_data;
	logic view_req;
	life_grid_pkg::row_addr_t view_row;
	logic busy;
	life_ctrl_pkg::gen_count_t gen_count;
	logic view_valid;
	life_grid_pkg::row_t view_data;

	// software grid and parsed records
	life_grid_pkg::row_t model [ROWS];
	life_ctrl_pkg::gen_count_t model_gens = '0;
	word_t rec_cmd [$];
	int rec_a [$];
	logic [31:0] rec_b [$];
	int limit = 0;
	int cycles = 0;
	int errors = 0;
	// busy run length and the count at its start
	int busy_len = 0;
	life_ctrl_pkg::gen_count_t busy_start = '0;

	life_top life_top_i (
		.clk         (clk),
		.reset       (reset),
		.button      (button),
		.load_strobe (load_strobe),
		.load_row    (load_row),
		.load_data   (load_data),
		.view_req    (view_req),
		.view_row    (view_row),
		.busy        (busy),
		.gen_count   (gen_count),
		.view_valid  (view_valid),
		.view_data   (view_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic stop_with_error(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("tests failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want) begin
			errors++;
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, want);
			stop_with_error("value mismatch");
		end
	endtask

	// one generation on the torus
	task automatic advance_model();
		life_grid_pkg::row_t nxt [ROWS];
		int n;
		for (int r = 0; r < ROWS; r++) begin
			for (int c = 0; c < COLS; c++) begin
				n = 0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						if (dr != 0 || dc != 0)
							n += int'(model[(r + dr + ROWS) % ROWS][(c + dc + COLS) % COLS]);
					end
				end
				// birth on three, survival on two or three
				nxt[r][c] = (n == 3) || (model[r][c] && n == 2);
			end
		end
		for (int r = 0; r < ROWS; r++)
			model[r] = nxt[r];
	endtask

	task automatic load_row_data(input int row, input life_grid_pkg::row_t data);
		@(posedge clk);
		load_strobe <= 1'b1;
		load_row <= life_grid_pkg::row_addr_t'(row);
		load_data <= data;
		@(posedge clk);
		load_strobe <= 1'b0;
		model[row] = data;
	endtask

	task automatic read_row(input int row, output life_grid_pkg::row_t data);
		@(posedge clk);
		view_req <= 1'b1;
		view_row <= life_grid_pkg::row_addr_t'(row);
		@(posedge clk);
		view_req <= 1'b0;
		@(negedge clk);
		while (view_valid !== 1'b1)
			@(negedge clk);
		data = view_data;
	endtask

	task automatic press_button(input int len);
		@(posedge clk);
		button <= 1'b1;
		repeat (len) @(posedge clk);
		button <= 1'b0;
		// debouncer back to idle, then any sweep drains
		repeat (SETTLE) @(posedge clk);
		@(negedge clk);
		while (busy !== 1'b0)
			@(negedge clk);
	endtask

	// parse the whole file first so the timeout limit is known
	task automatic read_stimulus();
		int fd;
		int n;
		int a;
		logic [31:0] b;
		word_t cmd;
		logic [8*160-1:0] line;
		int cycle_sum;
		int exp_gens;
		cycle_sum = 0;
		exp_gens = 0;
		fd = $fopen("life_stimulus.txt", "r");
		if (fd == 0)
			stop_with_error("cannot open life_stimulus.txt");
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", cmd);
			if (n == 1) begin
				a = 0;
				b = '0;
				if (cmd == word_t'("#")) begin
					n = $fgets(line, fd);
				end else begin
					if (cmd == word_t'("load") || cmd == word_t'("view"))
						n = $fscanf(fd, "%d %h", a, b);
					else if (cmd == word_t'("press") || cmd == word_t'("hold") ||
					         cmd == word_t'("gens"))
						n = $fscanf(fd, "%d", a);
					else if (cmd != word_t'("clear") && cmd != word_t'("grid"))
						stop_with_error("unknown record in life_stimulus.txt");
					if (cmd == word_t'("press")) begin
						cycle_sum += a;
						exp_gens += 1;
					end else if (cmd == word_t'("hold")) begin
						cycle_sum += a;
						exp_gens += a / SWEEP + 2;
					end
					rec_cmd.push_back(cmd);
					rec_a.push_back(a);
					rec_b.push_back(b);
				end
			end
		end
		$fclose(fd);
		limit = (cycle_sum + SWEEP * exp_gens) * 2 + 200;
	endtask

	//////////////////////////////////////////////////
	// model follows each observed generation
	//////////////////////////////////////////////////

	always @(negedge clk) begin
		if (!reset) begin
			while (model_gens < gen_count) begin
				advance_model();
				model_gens++;
			end
		end
	end

	// each busy stretch is a whole number of fixed-length sweeps
	always @(negedge clk) begin
		if (reset) begin
			busy_len = 0;
		end else if (busy === 1'b1) begin
			if (busy_len == 0)
				busy_start = gen_count;
			busy_len++;
		end else if (busy_len > 0) begin
			check_value("busy cycles", 32'(busy_len), 32'((gen_count - busy_start) * SWEEP));
			busy_len = 0;
		end
	end

	// watchdog
	initial begin
		forever begin
			@(posedge clk);
			cycles++;
			if (limit > 0 && cycles > limit)
				stop_with_error($sformatf("timeout, no finish after %0d cycles", cycles));
		end
	end

	//////////////////////////////////////////////////
	// main sequence
	//////////////////////////////////////////////////

	initial begin
		int a;
		logic [31:0] b;
		life_grid_pkg::row_t data;
		life_ctrl_pkg::gen_count_t start_count;
		life_ctrl_pkg::gen_count_t end_count;
		reset = 1'b1;
		button = 1'b0;
		load_strobe = 1'b0;
		load_row = '0;
		load_data = '0;
		view_req = 1'b0;
		view_row = '0;
		read_stimulus();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("gen_count", gen_count, 32'd0);
		check_value("busy", 32'(busy), 32'd0);
		check_value("view_valid", 32'(view_valid), 32'd0);
		for (int i = 0; i < rec_cmd.size(); i++) begin
			a = rec_a[i];
			b = rec_b[i];
			if (rec_cmd[i] == word_t'("clear")) begin
				for (int r = 0; r < ROWS; r++)
					load_row_data(r, '0);
			end else if (rec_cmd[i] == word_t'("load")) begin
				load_row_data(a, life_grid_pkg::row_t'(b));
			end else if (rec_cmd[i] == word_t'("view")) begin
				read_row(a, data);
				check_value($sformatf("view_data[row %0d]", a), 32'(data), b);
				check_value($sformatf("view_data[row %0d] vs model", a), 32'(data),
					32'(model[a]));
			end else if (rec_cmd[i] == word_t'("grid")) begin
				for (int r = 0; r < ROWS; r++) begin
					read_row(r, data);
					check_value($sformatf("view_data[row %0d] vs model", r), 32'(data),
						32'(model[r]));
				end
			end else if (rec_cmd[i] == word_t'("gens")) begin
				@(negedge clk);
				check_value("gen_count", gen_count, 32'(a));
			end else if (rec_cmd[i] == word_t'("press")) begin
				press_button(a);
			end else if (rec_cmd[i] == word_t'("hold")) begin
				start_count = gen_count;
				press_button(a);
				check_value("gen_count rise over one", 32'(gen_count - start_count > 1), 32'd1);
				// no more sweeps once the button is up
				end_count = gen_count;
				repeat (2 * SWEEP) @(negedge clk);
				check_value("gen_count after release", gen_count, end_count);
			end
		end
		@(posedge clk);
		if (errors == 0) begin
			$display("all tests passed");
			$finish;
		end else begin
			$display("tests failed");
			$fatal(1, "errors found");
		end
	end

endmodule

`default_nettype wire

// ==== life_top.sv ====
// game of life top level on one clock
// button steps or runs generations, rows load and view through side ports
`timescale 1ns/1ns
`default_nettype none

module life_top (
	input  wire                           clk,
	input  wire                           reset,
	input  wire                           button,
	input  wire                           load_strobe,
	input  wire life_grid_pkg::row_addr_t load_row,
	input  wire life_grid_pkg::row_t      load_data,
	input  wire                           view_req,
	input  wire life_grid_pkg::row_addr_t view_row,
	output logic                          busy,
	output life_ctrl_pkg::gen_count_t     gen_count,
	output logic                          view_valid,
	output life_grid_pkg::row_t           view_data
);

	logic step;
	logic run;
	life_grid_pkg::row_addr_t raddr;
	life_grid_pkg::row_addr_t waddr;
	logic wr_en;
	life_grid_pkg::row_t wr_data;
	life_grid_pkg::row_t rd_data;
	life_grid_pkg::row_t next_row;
	life_ctrl_pkg::seq_ctrl_t ctrl;

	//////////////////////////////////////////////////
	// button to step and run
	//////////////////////////////////////////////////

	button_debounce button_debounce_i (
		.clk    (clk),
		.reset  (reset),
		.button (button),
		.step   (step),
		.run    (run)
	);

	// sweeps, loads, views
	generation_sequencer generation_sequencer_i (
		.clk         (clk),
		.reset       (reset),
		.step        (step),
		.run         (run),
		.load_strobe (load_strobe),
		.load_row    (load_row),
		.load_data   (load_data),
		.view_req    (view_req),
		.view_row    (view_row),
		.rd_data     (rd_data),
		.next_row    (next_row),
		.raddr       (raddr),
		.waddr       (waddr),
		.wr_en       (wr_en),
		.wr_data     (wr_data),
		.ctrl        (ctrl),
		.busy        (busy),
		.gen_count   (gen_count),
		.view_valid  (view_valid),
		.view_data   (view_data)
	);

	//////////////////////////////////////////////////
	// memory and rule datapath
	//////////////////////////////////////////////////

	cell_ram cell_ram_i (
		.clk     (clk),
		.raddr   (raddr),
		.waddr   (waddr),
		.wr_en   (wr_en),
		.wr_data (wr_data),
		.rd_data (rd_data)
	);

	life_rule_pipe life_rule_pipe_i (
		.clk      (clk),
		.reset    (reset),
		.ctrl     (ctrl),
		.rd_data  (rd_data),
		.next_row (next_row)
	);

endmodule

`default_nettype wire

// ==== life_rule_pipe.sv ====
// life rule pipeline: three-row window, neighbour sums, next state
// next_row is valid PIPE_DELAY cycles after the lower row's read address
`timescale 1ns/1ns
`default_nettype none

module life_rule_pipe (
	input  wire                           clk,
	input  wire                           reset,
	input  wire life_ctrl_pkg::seq_ctrl_t ctrl,
	input  wire life_grid_pkg::row_t      rd_data,
	output life_grid_pkg::row_t           next_row
);

	// window, top row in win_top, newest row in win_bot
	life_grid_pkg::row_t win_top;
	life_grid_pkg::row_t win_mid;
	life_grid_pkg::row_t win_bot;
	life_grid_pkg::row_t row0_q;
	life_grid_pkg::row_t mid_q;
	logic [life_grid_pkg::GRID_COLS-1:0][1:0] col_sum;
	logic [life_grid_pkg::GRID_COLS-1:0][1:0] col_sum_q;
	life_grid_pkg::neighbour_sum_t [life_grid_pkg::GRID_COLS-1:0] block_sum;
	life_grid_pkg::row_t cell_next;
	logic shift_d;
	logic shift_dd;

	// stage valids follow the shift strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			shift_d <= 1'b0;
			shift_dd <= 1'b0;
		end else begin
			shift_d <= ctrl.shift;
			shift_dd <= shift_d;
		end
	end

	//////////////////////////////////////////////////
	// window and row 0 copy
	//////////////////////////////////////////////////

	// original row 0 kept for the wrap slot, memory copy is rewritten early
	always_ff @(posedge clk) begin
		if (ctrl.first)
			row0_q <= rd_data;
		if (ctrl.shift) begin
			win_top <= win_mid;
			win_mid <= win_bot;
			win_bot <= ctrl.wrap ? row0_q : rd_data;
		end
	end

	//////////////////////////////////////////////////
	// sums and rule
	//////////////////////////////////////////////////

	// vertical sum per column
	always_comb begin
		for (int c = 0; c < life_grid_pkg::GRID_COLS; c++) begin
			col_sum[c] = {1'b0, win_top[c]} + {1'b0, win_mid[c]} + {1'b0, win_bot[c]};
		end
	end

	always_ff @(posedge clk) begin
		if (shift_d) begin
			col_sum_q <= col_sum;
			mid_q <= win_mid;
		end
	end

	// add left and right column, wrapping at the row ends
	always_comb begin
		for (int c = 0; c < life_grid_pkg::GRID_COLS; c++) begin
			block_sum[c] =
				{2'b00, col_sum_q[(c + life_grid_pkg::GRID_COLS - 1) % life_grid_pkg::GRID_COLS]} +
				{2'b00, col_sum_q[c]} +
				{2'b00, col_sum_q[(c + 1) % life_grid_pkg::GRID_COLS]};
			// block of 3 always lives, 4 keeps a live centre alive
			cell_next[c] = (block_sum[c] == 4'd3) || ((block_sum[c] == 4'd4) && mid_q[c]);
		end
	end

	always_ff @(posedge clk) begin
		if (shift_dd)
			next_row <= cell_next;
	end

endmodule

`default_nettype wire

// ==== cell_ram.sv ====
// row-wide cell memory, one write port and one registered read port
// a read in the same cycle as a write to that row returns the old row
`timescale 1ns/1ns
`default_nettype none

module cell_ram (
	input  wire                           clk,
	input  wire life_grid_pkg::row_addr_t raddr,
	input  wire life_grid_pkg::row_addr_t waddr,
	input  wire                           wr_en,
	input  wire life_grid_pkg::row_t      wr_data,
	output life_grid_pkg::row_t           rd_data
);

	// one word per grid row
	life_grid_pkg::row_t mem [life_grid_pkg::GRID_ROWS];

	// write port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[waddr] <= wr_data;
	end

	// read port, data one cycle after address
	always_ff @(posedge clk) begin
		rd_data <= mem[raddr];
	end

endmodule

`default_nettype wire

// ==== generation_sequencer.sv ====
// sweep sequencer: row addresses, pipeline control, loads, views
// and the generation count; one sweep is one generation
`timescale 1ns/1ns
`default_nettype none

module generation_sequencer (
	input  wire                          clk,
	input  wire                          reset,
	input  wire                          step,
	input  wire                          run,
	input  wire                          load_strobe,
	input  wire life_grid_pkg::row_addr_t load_row,
	input  wire life_grid_pkg::row_t      load_data,
	input  wire                          view_req,
	input  wire life_grid_pkg::row_addr_t view_row,
	input  wire life_grid_pkg::row_t      rd_data,
	input  wire life_grid_pkg::row_t      next_row,
	output life_grid_pkg::row_addr_t     raddr,
	output life_grid_pkg::row_addr_t     waddr,
	output logic                         wr_en,
	output life_grid_pkg::row_t          wr_data,
	output life_ctrl_pkg::seq_ctrl_t     ctrl,
	output logic                         busy,
	output life_ctrl_pkg::gen_count_t    gen_count,
	output logic                         view_valid,
	output life_grid_pkg::row_t          view_data
);

	life_ctrl_pkg::seq_state_t state;
	life_ctrl_pkg::seq_state_t state_next;
	life_ctrl_pkg::seq_ctrl_t ctrl_next;
	life_grid_pkg::slot_t slot;
	logic sweep_end;
	logic step_pend;
	logic view_pend;
	logic view_rd;
	logic load_wr;
	life_grid_pkg::row_addr_t view_row_q;
	life_grid_pkg::row_addr_t load_row_q;
	life_grid_pkg::row_t load_data_q;

	assign sweep_end = (state == life_ctrl_pkg::SEQ_SWEEP) &&
	                   (slot == life_grid_pkg::SLOT_BITS'(life_grid_pkg::SWEEP_CYCLES - 1));

	//////////////////////////////////////////////////
	// next state and idle arbitration
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		unique case (state)
			life_ctrl_pkg::SEQ_IDLE:
				// load first, its write lands in the next idle cycle
				if (load_strobe)
					state_next = life_ctrl_pkg::SEQ_IDLE;
				else if (view_pend)
					state_next = life_ctrl_pkg::SEQ_VIEW;
				else if (step || step_pend || run)
					state_next = life_ctrl_pkg::SEQ_SWEEP;
			life_ctrl_pkg::SEQ_SWEEP:
				// pending view steals the restart cycle
				if (sweep_end)
					state_next = view_pend ? life_ctrl_pkg::SEQ_VIEW :
					             run ? life_ctrl_pkg::SEQ_SWEEP : life_ctrl_pkg::SEQ_IDLE;
			default:
				state_next = life_ctrl_pkg::SEQ_IDLE;
		endcase
	end

	// slot 0 reads the last row, 1..N rows 0..N-1, N+1 the wrap slot
	always_comb begin
		ctrl_next.shift = busy && (slot <= life_grid_pkg::SLOT_BITS'(life_grid_pkg::GRID_ROWS + 1));
		ctrl_next.first = busy && (slot == life_grid_pkg::SLOT_BITS'(1));
		ctrl_next.wrap = busy && (slot == life_grid_pkg::SLOT_BITS'(life_grid_pkg::GRID_ROWS + 1));
		// write window is the read window shifted by the pipe depth
		ctrl_next.write = busy &&
			(slot >= life_grid_pkg::SLOT_BITS'(life_grid_pkg::PIPE_DELAY + 1)) &&
			(slot <= life_grid_pkg::SLOT_BITS'(life_grid_pkg::GRID_ROWS + life_grid_pkg::PIPE_DELAY));
	end

	//////////////////////////////////////////////////
	// memory side
	//////////////////////////////////////////////////

	assign busy = (state == life_ctrl_pkg::SEQ_SWEEP);

	always_comb begin
		if (!busy)
			raddr = view_row_q;
		else if (slot == '0)
			raddr = life_grid_pkg::ROW_ADDR_BITS'(life_grid_pkg::GRID_ROWS - 1);
		else
			raddr = life_grid_pkg::ROW_ADDR_BITS'(slot - 1'b1);
	end

	// new row k goes out PIPE_DELAY after row k+1 was read
	assign waddr = load_wr ? load_row_q :
	               life_grid_pkg::ROW_ADDR_BITS'(slot - life_grid_pkg::SLOT_BITS'(life_grid_pkg::PIPE_DELAY + 2));
	assign wr_en = ctrl.write || load_wr;
	assign wr_data = load_wr ? load_data_q : next_row;

	//////////////////////////////////////////////////
	// control registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= life_ctrl_pkg::SEQ_IDLE;
			slot <= '0;
			ctrl <= '0;
			gen_count <= '0;
			step_pend <= 1'b0;
			view_pend <= 1'b0;
			view_rd <= 1'b0;
			view_valid <= 1'b0;
			load_wr <= 1'b0;
		end else begin
			state <= state_next;
			slot <= (busy && !sweep_end) ? slot + 1'b1 : '0;
			ctrl <= ctrl_next;
			if (sweep_end)
				gen_count <= gen_count + 1'b1;
			// step only counts from idle, held if the cycle is taken
			if (state_next == life_ctrl_pkg::SEQ_SWEEP)
				step_pend <= 1'b0;
			else if (step && state == life_ctrl_pkg::SEQ_IDLE)
				step_pend <= 1'b1;
			if (view_req)
				view_pend <= 1'b1;
			else if (state_next == life_ctrl_pkg::SEQ_VIEW)
				view_pend <= 1'b0;
			// read in view, data one later, valid two later
			view_rd <= (state == life_ctrl_pkg::SEQ_VIEW);
			view_valid <= view_rd;
			// loads during a sweep are dropped
			load_wr <= load_strobe && (state == life_ctrl_pkg::SEQ_IDLE);
		end
	end

	// request payloads
	always_ff @(posedge clk) begin
		if (view_req)
			view_row_q <= view_row;
		if (load_strobe) begin
			load_row_q <= load_row;
			load_data_q <= load_data;
		end
		if (view_rd)
			view_data <= rd_data;
	end

endmodule

`default_nettype wire

// ==== button_debounce.sv ====
// push button debouncer
// short press gives one step pulse, long hold gives the run level
`timescale 1ns/1ns
`default_nettype none

module button_debounce (
	input  wire  clk,
	input  wire  reset,
	input  wire  button,
	output logic step,
	output logic run
);

	logic [2:0] sync;
	logic btn;
	life_ctrl_pkg::debounce_state_t state;
	life_ctrl_pkg::debounce_state_t state_next;
	life_ctrl_pkg::timer_t press_cycles;
	life_ctrl_pkg::timer_t release_cycles;

	// async button into clk domain
	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '0;
		end else begin
			sync <= {sync[1:0], button};
		end
	end
	assign btn = sync[2];

	// press timer runs from the first touch, release timer while waiting off
	press_timer press_timer_i (
		.clk            (clk),
		.reset          (reset),
		.press_en       (state != life_ctrl_pkg::DB_IDLE),
		.release_en     (state == life_ctrl_pkg::DB_WAIT_OFF ||
		                 state == life_ctrl_pkg::DB_WAIT_LOFF),
		.press_cycles   (press_cycles),
		.release_cycles (release_cycles)
	);

	//////////////////////////////////////////////////
	// state machine
	//////////////////////////////////////////////////

	always_comb begin
		state_next = state;
		unique case (state)
			life_ctrl_pkg::DB_IDLE:
				if (btn) state_next = life_ctrl_pkg::DB_WAIT_PRESS;
			life_ctrl_pkg::DB_WAIT_PRESS:
				// bounce or too short, back to idle
				if (!btn)
					state_next = life_ctrl_pkg::DB_IDLE;
				else if (press_cycles == life_ctrl_pkg::TIMER_BITS'(life_ctrl_pkg::PRESS_MIN_CYCLES))
					state_next = life_ctrl_pkg::DB_PULSE;
			life_ctrl_pkg::DB_PULSE:
				if (press_cycles == life_ctrl_pkg::TIMER_BITS'(life_ctrl_pkg::PULSE_END_CYCLES))
					state_next = life_ctrl_pkg::DB_WAIT_LONG;
			life_ctrl_pkg::DB_WAIT_LONG:
				if (!btn)
					state_next = life_ctrl_pkg::DB_WAIT_OFF;
				else if (press_cycles >= life_ctrl_pkg::TIMER_BITS'(life_ctrl_pkg::LONG_CYCLES))
					state_next = life_ctrl_pkg::DB_LONG;
			life_ctrl_pkg::DB_LONG:
				if (!btn) state_next = life_ctrl_pkg::DB_WAIT_LOFF;
			life_ctrl_pkg::DB_WAIT_OFF:
				// press timer kept running, a re-press may go long at once
				if (btn)
					state_next = life_ctrl_pkg::DB_WAIT_LONG;
				else if (release_cycles == life_ctrl_pkg::TIMER_BITS'(life_ctrl_pkg::RELEASE_CYCLES))
					state_next = life_ctrl_pkg::DB_IDLE;
			life_ctrl_pkg::DB_WAIT_LOFF:
				if (btn)
					state_next = life_ctrl_pkg::DB_LONG;
				else if (release_cycles == life_ctrl_pkg::TIMER_BITS'(life_ctrl_pkg::RELEASE_CYCLES))
					state_next = life_ctrl_pkg::DB_IDLE;
			default:
				state_next = life_ctrl_pkg::DB_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= life_ctrl_pkg::DB_IDLE;
			step <= 1'b0;
		end else begin
			state <= state_next;
			// one cycle on entry to pulse
			step <= (state_next == life_ctrl_pkg::DB_PULSE) &&
			        (state != life_ctrl_pkg::DB_PULSE);
		end
	end

	// held through the release wait, so a quick re-grab keeps running
	assign run = (state == life_ctrl_pkg::DB_LONG) || (state == life_ctrl_pkg::DB_WAIT_LOFF);

endmodule

`default_nettype wire

// ==== press_timer.sv ====
// press and release duration counters for the button debouncer
// each counter runs while its enable is high and clears when it drops
`timescale 1ns/1ns
`default_nettype none

module press_timer (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   press_en,
	input  wire                   release_en,
	output life_ctrl_pkg::timer_t press_cycles,
	output life_ctrl_pkg::timer_t release_cycles
);

	// press side, saturates so a long hold never wraps to zero
	always_ff @(posedge clk) begin
		if (reset) begin
			press_cycles <= '0;
		end else if (!press_en) begin
			press_cycles <= '0;
		end else if (press_cycles != '1) begin
			press_cycles <= press_cycles + 1'b1;
		end
	end

	// release side
	always_ff @(posedge clk) begin
		if (reset) begin
			release_cycles <= '0;
		end else if (!release_en) begin
			release_cycles <= '0;
		end else if (release_cycles != '1) begin
			release_cycles <= release_cycles + 1'b1;
		end
	end

	// both counters restart from zero on each enable rise

endmodule

`default_nettype wire

// ==== life_ctrl_pkg.sv ====
// button timing, counter widths and control types
// shared by the debouncer, the sequencer and the rule pipeline
`default_nettype none

package life_ctrl_pkg;

	//////////////////////////////////////////////////
	// debounce timing, in clk cycles
	//////////////////////////////////////////////////

	localparam int PRESS_MIN_CYCLES = 8;
	localparam int PULSE_END_CYCLES = 12;
	localparam int LONG_CYCLES = 64;
	localparam int RELEASE_CYCLES = 16;

	localparam int TIMER_BITS = 8;
	localparam int GEN_COUNT_BITS = 32;

	typedef logic [TIMER_BITS-1:0] timer_t;
	typedef logic [GEN_COUNT_BITS-1:0] gen_count_t;

	// button state machine
	typedef enum logic [2:0] {
		DB_IDLE,
		DB_WAIT_PRESS,
		DB_PULSE,
		DB_WAIT_LONG,
		DB_LONG,
		DB_WAIT_OFF,
		DB_WAIT_LOFF
	} debounce_state_t;

	// sweep sequencer
	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_SWEEP,
		SEQ_VIEW
	} seq_state_t;

	// sequencer to pipeline, aligned with rd_data
	typedef struct packed {
		logic shift;
		logic first;
		logic wrap;
		logic write;
	} seq_ctrl_t;

endpackage

`default_nettype wire

// ==== life_grid_pkg.sv ====
// grid geometry and row types for the life engine
// used by the sequencer, the cell memory and the rule pipeline
`default_nettype none

package life_grid_pkg;

	//////////////////////////////////////////////////
	// grid size
	//////////////////////////////////////////////////

	// torus, both edges wrap
	localparam int GRID_COLS = 16;
	localparam int GRID_ROWS = 16;
	localparam int ROW_ADDR_BITS = $clog2(GRID_ROWS);

	// read address to write of the predecessor's new row
	localparam int PIPE_DELAY = 4;

	// lead row, grid rows, wrap slot, pipe drain
	localparam int SWEEP_CYCLES = GRID_ROWS + PIPE_DELAY + 2;
	localparam int SLOT_BITS = $clog2(SWEEP_CYCLES);

	//////////////////////////////////////////////////
	// types
	//////////////////////////////////////////////////

	typedef logic [GRID_COLS-1:0] row_t;
	typedef logic [ROW_ADDR_BITS-1:0] row_addr_t;
	// live cells in a 3x3 block, 0..9
	typedef logic [3:0] neighbour_sum_t;
	// position inside one sweep
	typedef logic [SLOT_BITS-1:0] slot_t;

endpackage

`default_nettype wire
